//--- mips_id_ex.f
verilog/mips_pkg.sv
verilog/id_control.sv
verilog/id_register_file.sv
verilog/id_ex_register.sv
verilog/ex_stage.sv
verilog/mips_id_ex_top.sv
verification/tb_mips_id_ex.sv

//--- verification/tb_mips_id_ex.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_id_ex
    import mips_pkg::*;
();

    localparam int N_RAND       = 8;
    localparam int TOTAL_CYCLES = 8 + 100 + 29 * N_RAND + 4;

    localparam logic [1:0] KIND_NONE  = 2'd0;
    localparam logic [1:0] KIND_RESET = 2'd1;
    localparam logic [1:0] KIND_INSTR = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] alu;
        logic [31:0] store_data;
        logic [31:0] target;
        logic [4:0]  wreg;
        logic        taken;
        logic        rwr;
        logic        mw;
        logic        mr;
        logic        m2r;
        logic        lui;
        logic        lzx;
        logic [1:0]  ssz;
        logic [1:0]  lsz;
    } expect_t;

    logic        i_clk;
    logic        i_rst_n;
    logic [31:0] i_instruction;
    logic [31:0] i_pc4;
    logic        i_wb_reg_write;
    logic [4:0]  i_wb_addr;
    logic [31:0] i_wb_data;
    logic [31:0] o_alu_result;
    logic [31:0] o_store_data;
    logic [4:0]  o_write_reg;
    logic        o_branch_taken;
    logic [31:0] o_branch_target;
    logic        o_mem_write;
    logic        o_mem_read;
    mem_size_e   o_store_size;
    logic        o_mem_to_reg;
    logic        o_reg_write;
    mem_size_e   o_load_size;
    logic        o_load_zero_extend;
    logic        o_lui;

    logic [31:0] model [0:31];
    logic [31:0] seed;
    int          errors;
    expect_t     next_exp;
    expect_t     cur_exp;
    string       next_name;
    string       cur_name;

    funct_e fn_list  [11] = '{FN_SLL, FN_SRL, FN_SRA, FN_ADDU, FN_SUBU, FN_AND,
                              FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    op_e    imm_list [6]  = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    op_e    mem_list [8]  = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};

    mips_id_ex_top uut (.*);

    always #4 i_clk = ~i_clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] r_type(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                           logic [4:0] sh, logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Expected outputs for one instruction against the register model
    task automatic predict(input logic [31:0] instr, input logic [31:0] pc4);
        logic [5:0]  op;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ext;
        op  = instr[31:26];
        sh  = instr[10:6];
        a   = model[instr[25:21]];
        b   = model[instr[20:16]];
        ext = (op == OP_ANDI || op == OP_ORI || op == OP_XORI) ? {16'h0000, instr[15:0]}
                                                               : {{16{instr[15]}}, instr[15:0]};
        next_exp            = '0;
        next_exp.kind       = KIND_INSTR;
        next_exp.wreg       = instr[20:16];
        next_exp.store_data = b;
        next_exp.target     = pc4 + (ext << 2);
        case (op)
            OP_RTYPE:
            begin
                next_exp.rwr  = 1'b1;
                next_exp.wreg = instr[15:11];
                case (instr[5:0])
                    FN_SLL:  next_exp.alu = b << sh;
                    FN_SRL:  next_exp.alu = b >> sh;
                    FN_SRA:  next_exp.alu = $signed(b) >>> sh;
                    FN_ADDU: next_exp.alu = a + b;
                    FN_SUBU: next_exp.alu = a - b;
                    FN_AND:  next_exp.alu = a & b;
                    FN_OR:   next_exp.alu = a | b;
                    FN_XOR:  next_exp.alu = a ^ b;
                    FN_NOR:  next_exp.alu = ~(a | b);
                    FN_SLT:  next_exp.alu = {31'b0, $signed(a) < $signed(b)};
                    FN_SLTU: next_exp.alu = {31'b0, a < b};
                    default: next_exp.alu = '0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                next_exp.rwr = 1'b1;
                next_exp.lui = (op == OP_LUI);
                case (op)
                    OP_ADDIU: next_exp.alu = a + ext;
                    OP_SLTI:  next_exp.alu = {31'b0, $signed(a) < $signed(ext)};
                    OP_ANDI:  next_exp.alu = a & ext;
                    OP_ORI:   next_exp.alu = a | ext;
                    OP_XORI:  next_exp.alu = a ^ ext;
                    default:  next_exp.alu = {instr[15:0], 16'h0000};
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
            begin
                next_exp.alu = a + ext;
                next_exp.mr  = 1'b1;
                next_exp.m2r = 1'b1;
                next_exp.rwr = 1'b1;
                next_exp.lzx = (op == OP_LBU || op == OP_LHU);
                next_exp.lsz = (op == OP_LW) ? SZ_WORD :
                               (op == OP_LB || op == OP_LBU) ? SZ_BYTE : SZ_HALF;
            end
            OP_SB, OP_SH, OP_SW:
            begin
                next_exp.alu = a + ext;
                next_exp.mw  = 1'b1;
                next_exp.ssz = (op == OP_SW) ? SZ_WORD : (op == OP_SH) ? SZ_HALF : SZ_BYTE;
            end
            OP_BEQ, OP_BNE:
            begin
                next_exp.alu   = a - b;
                next_exp.taken = (op == OP_BEQ) ? (a == b) : (a != b);
            end
            default:
            begin
            end
        endcase
    endtask

    // Called one ns after an edge; returns one ns after the next edge
    task automatic step(input string name, input logic [31:0] instr, input logic wb_en,
                        input logic [4:0] wb_addr, input logic [31:0] wb_data);
        logic [31:0] pc;
        pc             = next_rand() & 32'hffff_fffc;
        i_instruction  = instr;
        i_pc4          = pc;
        i_wb_reg_write = wb_en;
        i_wb_addr      = wb_addr;
        i_wb_data      = wb_data;
        if (wb_en && wb_addr != 5'd0)
            model[wb_addr] = wb_data;
        predict(instr, pc);
        next_name = name;
        @(posedge i_clk);
        #1;
    endtask

    task automatic step_rand_wb(input string name, input logic [31:0] instr);
        logic [31:0] r;
        r = next_rand();
        step(name, instr, r[0], r[5:1], next_rand());
    endtask

    task automatic mismatch(input string field, input logic [31:0] exp, input logic [31:0] act);
        $display("CHECK FAILED %s %s expected %h actual %h", cur_name, field, exp, act);
        errors++;
    endtask

    always @(posedge i_clk)
    begin
        cur_exp  <= next_exp;
        cur_name <= next_name;
    end

    // Compare half a cycle after each capture
    always @(negedge i_clk)
    begin
        if (cur_exp.kind == KIND_RESET)
        begin
            assert (o_reg_write === 1'b0) else mismatch("o_reg_write", 0, o_reg_write);
            assert (o_mem_write === 1'b0) else mismatch("o_mem_write", 0, o_mem_write);
            assert (o_mem_read === 1'b0) else mismatch("o_mem_read", 0, o_mem_read);
            assert (o_mem_to_reg === 1'b0) else mismatch("o_mem_to_reg", 0, o_mem_to_reg);
            assert (o_branch_taken === 1'b0) else mismatch("o_branch_taken", 0, o_branch_taken);
            assert (o_alu_result === '0) else mismatch("o_alu_result", 0, o_alu_result);
        end
        else if (cur_exp.kind == KIND_INSTR)
        begin
            assert (o_alu_result === cur_exp.alu)
                else mismatch("o_alu_result", cur_exp.alu, o_alu_result);
            assert (o_store_data === cur_exp.store_data)
                else mismatch("o_store_data", cur_exp.store_data, o_store_data);
            assert (o_write_reg === cur_exp.wreg)
                else mismatch("o_write_reg", cur_exp.wreg, o_write_reg);
            assert (o_branch_target === cur_exp.target)
                else mismatch("o_branch_target", cur_exp.target, o_branch_target);
            assert (o_branch_taken === cur_exp.taken)
                else mismatch("o_branch_taken", cur_exp.taken, o_branch_taken);
            assert (o_reg_write === cur_exp.rwr)
                else mismatch("o_reg_write", cur_exp.rwr, o_reg_write);
            assert (o_mem_write === cur_exp.mw)
                else mismatch("o_mem_write", cur_exp.mw, o_mem_write);
            assert (o_mem_read === cur_exp.mr)
                else mismatch("o_mem_read", cur_exp.mr, o_mem_read);
            assert (o_mem_to_reg === cur_exp.m2r)
                else mismatch("o_mem_to_reg", cur_exp.m2r, o_mem_to_reg);
            assert (o_lui === cur_exp.lui) else mismatch("o_lui", cur_exp.lui, o_lui);
            if (cur_exp.mr)
            begin
                assert (o_load_size === cur_exp.lsz)
                    else mismatch("o_load_size", cur_exp.lsz, o_load_size);
                assert (o_load_zero_extend === cur_exp.lzx)
                    else mismatch("o_load_zero_extend", cur_exp.lzx, o_load_zero_extend);
            end
            if (cur_exp.mw)
                assert (o_store_size === cur_exp.ssz)
                    else mismatch("o_store_size", cur_exp.ssz, o_store_size);
        end
    end

    initial
    begin
        #(2 * TOTAL_CYCLES * 8);
        $display("Timeout: the stimulus did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        seed           = 32'hbdb9_c1aa;
        errors         = 0;
        i_clk          = 1'b0;
        i_rst_n        = 1'b0;
        i_instruction  = '0;
        i_pc4          = '0;
        i_wb_reg_write = 1'b0;
        i_wb_addr      = '0;
        i_wb_data      = '0;
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        next_exp      = '0;
        next_exp.kind = KIND_RESET;
        cur_exp       = '0;
        next_name     = "reset";
        repeat (8) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        // Fill the register file, then read every register on both ports
        for (int i = 1; i < 32; i++)
            step("regfile_load", 32'h0, 1'b1, 5'(i), next_rand());
        step("regfile_r0_write", 32'h0, 1'b1, 5'd0, 32'hdead_beef);
        for (int i = 0; i < 32; i++)
        begin
            step("regfile_rs", r_type(5'(i), 5'd0, 5'd1, 5'd0, FN_ADDU), 1'b0, 5'd0, '0);
            step("regfile_rt", r_type(5'd0, 5'(i), 5'd2, 5'd0, FN_ADDU), 1'b0, 5'd0, '0);
        end
        for (int i = 0; i < 4; i++)
        begin
            rs = 5'(1 + next_rand() % 31);
            step("regfile_bypass", r_type(rs, rs, 5'd3, 5'd0, FN_OR), 1'b1, rs, next_rand());
        end

        for (int f = 0; f < 11; f++)
            for (int n = 0; n < N_RAND; n++)
            begin
                r = next_rand();
                step_rand_wb($sformatf("rtype_fn%02h", fn_list[f]),
                             r_type(r[25:21], r[20:16], r[15:11], r[10:6], fn_list[f]));
            end
        for (int k = 0; k < 6; k++)
            for (int n = 0; n < N_RAND; n++)
            begin
                r = next_rand();
                step_rand_wb($sformatf("imm_op%02h", imm_list[k]),
                             i_type(imm_list[k], r[25:21], r[20:16], r[15:0]));
            end
        for (int k = 0; k < 8; k++)
            for (int n = 0; n < N_RAND; n++)
            begin
                r = next_rand();
                step_rand_wb($sformatf("mem_op%02h", mem_list[k]),
                             i_type(mem_list[k], r[25:21], r[20:16], r[15:0]));
            end

        for (int n = 0; n < N_RAND; n++)
        begin
            r  = next_rand();
            rs = r[25:21];
            rt = (r[20:16] == rs) ? rs + 5'd1 : r[20:16];
            step("beq_equal", i_type(OP_BEQ, rs, rs, r[15:0]), 1'b0, 5'd0, '0);
            step("beq_unequal", i_type(OP_BEQ, rs, rt, r[15:0]), 1'b0, 5'd0, '0);
            step("bne_equal", i_type(OP_BNE, rt, rt, r[15:0]), 1'b0, 5'd0, '0);
            step("bne_unequal", i_type(OP_BNE, rs, rt, r[15:0]), 1'b0, 5'd0, '0);
        end

        next_exp.kind = KIND_NONE;
        repeat (2) @(posedge i_clk);
        $display("Run complete with %0d errors", errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mips_id_ex_top.sv
`timescale 1ns/100ps
`default_nettype none

module mips_id_ex_top
    import mips_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic [XLEN-1:0]       i_instruction,
    input  wire logic [XLEN-1:0]       i_pc4,
    input  wire logic                  i_wb_reg_write,
    input  wire logic [REG_ADDR_W-1:0] i_wb_addr,
    input  wire logic [XLEN-1:0]       i_wb_data,
    output logic      [XLEN-1:0]       o_alu_result,
    output logic      [XLEN-1:0]       o_store_data,
    output logic      [REG_ADDR_W-1:0] o_write_reg,
    output logic                       o_branch_taken,
    output logic      [XLEN-1:0]       o_branch_target,
    output logic                       o_mem_write,
    output logic                       o_mem_read,
    output mem_size_e                  o_store_size,
    output logic                       o_mem_to_reg,
    output logic                       o_reg_write,
    output mem_size_e                  o_load_size,
    output logic                       o_load_zero_extend,
    output logic                       o_lui
);

    // Decode side
    logic            id_alu_src;
    alu_class_e      id_alu_class;
    logic            id_reg_dst;
    logic            id_branch;
    logic            id_nbranch;
    logic            id_mem_write;
    logic            id_mem_read;
    mem_size_e       id_store_size;
    logic            id_mem_to_reg;
    logic            id_reg_write;
    mem_size_e       id_load_size;
    logic            id_load_zero_extend;
    logic            id_lui;
    logic [XLEN-1:0] id_extension;
    logic [XLEN-1:0] id_rs_data;
    logic [XLEN-1:0] id_rt_data;

    // Execute side
    logic [XLEN-1:0]       ex_pc4;
    logic [XLEN-1:0]       ex_instruction;
    logic [XLEN-1:0]       ex_reg1;
    logic [XLEN-1:0]       ex_reg2;
    logic [XLEN-1:0]       ex_extension;
    logic [REG_ADDR_W-1:0] ex_rt;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  ex_alu_src;
    alu_class_e            ex_alu_class;
    logic                  ex_reg_dst;
    logic                  ex_branch;
    logic                  ex_nbranch;

    id_control u_id_control (
        .i_instruction      (i_instruction),
        .o_alu_src          (id_alu_src),
        .o_alu_class        (id_alu_class),
        .o_reg_dst          (id_reg_dst),
        .o_branch           (id_branch),
        .o_nbranch          (id_nbranch),
        .o_mem_write        (id_mem_write),
        .o_mem_read         (id_mem_read),
        .o_store_size       (id_store_size),
        .o_mem_to_reg       (id_mem_to_reg),
        .o_reg_write        (id_reg_write),
        .o_load_size        (id_load_size),
        .o_load_zero_extend (id_load_zero_extend),
        .o_lui              (id_lui),
        .o_extension        (id_extension)
    );

    id_register_file u_id_register_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs_addr (i_instruction[25:21]),
        .i_rt_addr (i_instruction[20:16]),
        .i_wr_en   (i_wb_reg_write),
        .i_wr_addr (i_wb_addr),
        .i_wr_data (i_wb_data),
        .o_rs_data (id_rs_data),
        .o_rt_data (id_rt_data)
    );

    id_ex_register u_id_ex_register (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_pc4              (i_pc4),
        .i_instruction      (i_instruction),
        .i_reg1             (id_rs_data),
        .i_reg2             (id_rt_data),
        .i_extension        (id_extension),
        .i_rt               (i_instruction[20:16]),
        .i_rd               (i_instruction[15:11]),
        .i_alu_src          (id_alu_src),
        .i_alu_class        (id_alu_class),
        .i_reg_dst          (id_reg_dst),
        .i_branch           (id_branch),
        .i_nbranch          (id_nbranch),
        .i_mem_write        (id_mem_write),
        .i_mem_read         (id_mem_read),
        .i_store_size       (id_store_size),
        .i_mem_to_reg       (id_mem_to_reg),
        .i_reg_write        (id_reg_write),
        .i_load_size        (id_load_size),
        .i_load_zero_extend (id_load_zero_extend),
        .i_lui              (id_lui),
        .o_pc4              (ex_pc4),
        .o_instruction      (ex_instruction),
        .o_reg1             (ex_reg1),
        .o_reg2             (ex_reg2),
        .o_extension        (ex_extension),
        .o_rt               (ex_rt),
        .o_rd               (ex_rd),
        .o_alu_src          (ex_alu_src),
        .o_alu_class        (ex_alu_class),
        .o_reg_dst          (ex_reg_dst),
        .o_branch           (ex_branch),
        .o_nbranch          (ex_nbranch),
        .o_mem_write        (o_mem_write),
        .o_mem_read         (o_mem_read),
        .o_store_size       (o_store_size),
        .o_mem_to_reg       (o_mem_to_reg),
        .o_reg_write        (o_reg_write),
        .o_load_size        (o_load_size),
        .o_load_zero_extend (o_load_zero_extend),
        .o_lui              (o_lui)
    );

    ex_stage u_ex_stage (
        .i_pc4           (ex_pc4),
        .i_instruction   (ex_instruction),
        .i_reg1          (ex_reg1),
        .i_reg2          (ex_reg2),
        .i_extension     (ex_extension),
        .i_rt            (ex_rt),
        .i_rd            (ex_rd),
        .i_alu_src       (ex_alu_src),
        .i_alu_class     (ex_alu_class),
        .i_reg_dst       (ex_reg_dst),
        .i_branch        (ex_branch),
        .i_nbranch       (ex_nbranch),
        .o_alu_result    (o_alu_result),
        .o_store_data    (o_store_data),
        .o_write_reg     (o_write_reg),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target)
    );

endmodule

`default_nettype wire

//--- verilog/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage
    import mips_pkg::*;
(
    input  wire logic [XLEN-1:0]       i_pc4,
    input  wire logic [XLEN-1:0]       i_instruction,
    input  wire logic [XLEN-1:0]       i_reg1,
    input  wire logic [XLEN-1:0]       i_reg2,
    input  wire logic [XLEN-1:0]       i_extension,
    input  wire logic [REG_ADDR_W-1:0] i_rt,
    input  wire logic [REG_ADDR_W-1:0] i_rd,
    input  wire logic                  i_alu_src,
    input  wire alu_class_e            i_alu_class,
    input  wire logic                  i_reg_dst,
    input  wire logic                  i_branch,
    input  wire logic                  i_nbranch,
    output logic      [XLEN-1:0]       o_alu_result,
    output logic      [XLEN-1:0]       o_store_data,
    output logic      [REG_ADDR_W-1:0] o_write_reg,
    output logic                       o_branch_taken,
    output logic      [XLEN-1:0]       o_branch_target
);

    op_e         opcode;
    funct_e      funct;
    logic [4:0]  shamt;
    logic [XLEN-1:0] operand_b;
    logic        lt_signed;
    logic        lt_unsigned;
    logic        equal;

    assign opcode = op_e'(i_instruction[31:26]);
    assign funct  = funct_e'(i_instruction[5:0]);
    assign shamt  = i_instruction[10:6];

    assign operand_b   = i_alu_src ? i_extension : i_reg2;
    assign lt_signed   = $signed(i_reg1) < $signed(operand_b);
    assign lt_unsigned = i_reg1 < operand_b;

    always_comb
    begin
        o_alu_result = '0;
        case (i_alu_class)
            ALU_ADD:
                o_alu_result = i_reg1 + operand_b;
            ALU_SUB:
                o_alu_result = i_reg1 - operand_b;
            ALU_FUNCT:
            begin
                // Shifts operate on rt by shamt
                case (funct)
                    FN_SLL:  o_alu_result = i_reg2 << shamt;
                    FN_SRL:  o_alu_result = i_reg2 >> shamt;
                    FN_SRA:  o_alu_result = $signed(i_reg2) >>> shamt;
                    FN_ADDU: o_alu_result = i_reg1 + operand_b;
                    FN_SUBU: o_alu_result = i_reg1 - operand_b;
                    FN_AND:  o_alu_result = i_reg1 & operand_b;
                    FN_OR:   o_alu_result = i_reg1 | operand_b;
                    FN_XOR:  o_alu_result = i_reg1 ^ operand_b;
                    FN_NOR:  o_alu_result = ~(i_reg1 | operand_b);
                    FN_SLT:  o_alu_result = {{(XLEN-1){1'b0}}, lt_signed};
                    FN_SLTU: o_alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
                    default: o_alu_result = '0;
                endcase
            end
            ALU_IMM:
            begin
                case (opcode)
                    OP_ADDIU: o_alu_result = i_reg1 + operand_b;
                    OP_SLTI:  o_alu_result = {{(XLEN-1){1'b0}}, lt_signed};
                    OP_ANDI:  o_alu_result = i_reg1 & operand_b;
                    OP_ORI:   o_alu_result = i_reg1 | operand_b;
                    OP_XORI:  o_alu_result = i_reg1 ^ operand_b;
                    OP_LUI:   o_alu_result = {operand_b[15:0], 16'h0000};
                    default:  o_alu_result = '0;
                endcase
            end
            default:
                o_alu_result = '0;
        endcase
    end

    assign o_write_reg  = i_reg_dst ? i_rd : i_rt;
    assign o_store_data = i_reg2;

    // Branches run as a subtract, so equality is a zero result
    assign equal           = (o_alu_result == '0);
    assign o_branch_taken  = (i_branch && equal) || (i_nbranch && !equal);
    assign o_branch_target = i_pc4 + {i_extension[XLEN-3:0], 2'b00};

endmodule

`default_nettype wire

//--- verilog/id_ex_register.sv
`timescale 1ns/100ps
`default_nettype none

module id_ex_register
    import mips_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic [XLEN-1:0]       i_pc4,
    input  wire logic [XLEN-1:0]       i_instruction,
    input  wire logic [XLEN-1:0]       i_reg1,
    input  wire logic [XLEN-1:0]       i_reg2,
    input  wire logic [XLEN-1:0]       i_extension,
    input  wire logic [REG_ADDR_W-1:0] i_rt,
    input  wire logic [REG_ADDR_W-1:0] i_rd,
    input  wire logic                  i_alu_src,
    input  wire alu_class_e            i_alu_class,
    input  wire logic                  i_reg_dst,
    input  wire logic                  i_branch,
    input  wire logic                  i_nbranch,
    input  wire logic                  i_mem_write,
    input  wire logic                  i_mem_read,
    input  wire mem_size_e             i_store_size,
    input  wire logic                  i_mem_to_reg,
    input  wire logic                  i_reg_write,
    input  wire mem_size_e             i_load_size,
    input  wire logic                  i_load_zero_extend,
    input  wire logic                  i_lui,
    output logic      [XLEN-1:0]       o_pc4,
    output logic      [XLEN-1:0]       o_instruction,
    output logic      [XLEN-1:0]       o_reg1,
    output logic      [XLEN-1:0]       o_reg2,
    output logic      [XLEN-1:0]       o_extension,
    output logic      [REG_ADDR_W-1:0] o_rt,
    output logic      [REG_ADDR_W-1:0] o_rd,
    output logic                       o_alu_src,
    output alu_class_e                 o_alu_class,
    output logic                       o_reg_dst,
    output logic                       o_branch,
    output logic                       o_nbranch,
    output logic                       o_mem_write,
    output logic                       o_mem_read,
    output mem_size_e                  o_store_size,
    output logic                       o_mem_to_reg,
    output logic                       o_reg_write,
    output mem_size_e                  o_load_size,
    output logic                       o_load_zero_extend,
    output logic                       o_lui
);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_pc4              <= '0;
            o_instruction      <= '0;
            o_reg1             <= '0;
            o_reg2             <= '0;
            o_extension        <= '0;
            o_rt               <= '0;
            o_rd               <= '0;
            o_alu_src          <= 1'b0;
            o_alu_class        <= ALU_ADD;
            o_reg_dst          <= 1'b0;
            o_branch           <= 1'b0;
            o_nbranch          <= 1'b0;
            o_mem_write        <= 1'b0;
            o_mem_read         <= 1'b0;
            o_store_size       <= SZ_BYTE;
            o_mem_to_reg       <= 1'b0;
            o_reg_write        <= 1'b0;
            o_load_size        <= SZ_BYTE;
            o_load_zero_extend <= 1'b0;
            o_lui              <= 1'b0;
        end
        else
        begin
            o_pc4              <= i_pc4;
            o_instruction      <= i_instruction;
            o_reg1             <= i_reg1;
            o_reg2             <= i_reg2;
            o_extension        <= i_extension;
            o_rt               <= i_rt;
            o_rd               <= i_rd;
            // EX
            o_alu_src          <= i_alu_src;
            o_alu_class        <= i_alu_class;
            o_reg_dst          <= i_reg_dst;
            // M
            o_branch           <= i_branch;
            o_nbranch          <= i_nbranch;
            o_mem_write        <= i_mem_write;
            o_mem_read         <= i_mem_read;
            o_store_size       <= i_store_size;
            // WB
            o_mem_to_reg       <= i_mem_to_reg;
            o_reg_write        <= i_reg_write;
            o_load_size        <= i_load_size;
            o_load_zero_extend <= i_load_zero_extend;
            o_lui              <= i_lui;
        end
    end

endmodule

`default_nettype wire

//--- verilog/id_register_file.sv
`timescale 1ns/100ps
`default_nettype none

module id_register_file
    import mips_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic [REG_ADDR_W-1:0] i_rs_addr,
    input  wire logic [REG_ADDR_W-1:0] i_rt_addr,
    input  wire logic                  i_wr_en,
    input  wire logic [REG_ADDR_W-1:0] i_wr_addr,
    input  wire logic [XLEN-1:0]       i_wr_data,
    output logic      [XLEN-1:0]       o_rs_data,
    output logic      [XLEN-1:0]       o_rt_data
);

    // r0 has no storage
    logic [XLEN-1:0] regs [1:31];
    logic            wr_active;

    assign wr_active = i_wr_en && (i_wr_addr != '0);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_active)
            regs[i_wr_addr] <= i_wr_data;
    end

    // Write-through so a same-cycle writeback is seen by decode
    assign o_rs_data = (i_rs_addr == '0) ? '0 :
                       (wr_active && i_wr_addr == i_rs_addr) ? i_wr_data : regs[i_rs_addr];
    assign o_rt_data = (i_rt_addr == '0) ? '0 :
                       (wr_active && i_wr_addr == i_rt_addr) ? i_wr_data : regs[i_rt_addr];

endmodule

`default_nettype wire

//--- verilog/id_control.sv
`timescale 1ns/100ps
`default_nettype none

module id_control
    import mips_pkg::*;
(
    input  wire logic [XLEN-1:0] i_instruction,
    // EX group
    output logic                 o_alu_src,
    output alu_class_e           o_alu_class,
    output logic                 o_reg_dst,
    // M group
    output logic                 o_branch,
    output logic                 o_nbranch,
    output logic                 o_mem_write,
    output logic                 o_mem_read,
    output mem_size_e            o_store_size,
    // WB group
    output logic                 o_mem_to_reg,
    output logic                 o_reg_write,
    output mem_size_e            o_load_size,
    output logic                 o_load_zero_extend,
    output logic                 o_lui,
    output logic [XLEN-1:0]      o_extension
);

    op_e         opcode;
    logic [15:0] imm;
    logic        zero_ext;

    assign opcode = op_e'(i_instruction[31:26]);
    assign imm    = i_instruction[15:0];

    // Logic immediates are unsigned
    assign zero_ext    = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
    assign o_extension = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    always_comb
    begin
        o_alu_src          = 1'b0;
        o_alu_class        = ALU_ADD;
        o_reg_dst          = 1'b0;
        o_branch           = 1'b0;
        o_nbranch          = 1'b0;
        o_mem_write        = 1'b0;
        o_mem_read         = 1'b0;
        o_store_size       = SZ_BYTE;
        o_mem_to_reg       = 1'b0;
        o_reg_write        = 1'b0;
        o_load_size        = SZ_BYTE;
        o_load_zero_extend = 1'b0;
        o_lui              = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                o_alu_class = ALU_FUNCT;
                o_reg_dst   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                o_alu_src   = 1'b1;
                o_alu_class = ALU_IMM;
                o_reg_write = 1'b1;
                o_lui       = (opcode == OP_LUI);
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
            begin
                o_alu_src          = 1'b1;
                o_mem_read         = 1'b1;
                o_mem_to_reg       = 1'b1;
                o_reg_write        = 1'b1;
                o_load_zero_extend = (opcode == OP_LBU) || (opcode == OP_LHU);
                if (opcode == OP_LW)
                    o_load_size = SZ_WORD;
                else if (opcode == OP_LH || opcode == OP_LHU)
                    o_load_size = SZ_HALF;
            end
            OP_SB, OP_SH, OP_SW:
            begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
                if (opcode == OP_SW)
                    o_store_size = SZ_WORD;
                else if (opcode == OP_SH)
                    o_store_size = SZ_HALF;
            end
            OP_BEQ:
            begin
                o_alu_class = ALU_SUB;
                o_branch    = 1'b1;
            end
            OP_BNE:
            begin
                o_alu_class = ALU_SUB;
                o_nbranch   = 1'b1;
            end
            // Unknown opcodes fall through as a no-op
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_LHU   = 6'h25,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2b
    } op_e;

    // R-type funct field, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'd0,
        ALU_SUB   = 2'd1,
        ALU_FUNCT = 2'd2,
        ALU_IMM   = 2'd3
    } alu_class_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

endpackage

`default_nettype wire
